//--- include/core_settings.svh
`ifndef CORE_SETTINGS_SVH
`define CORE_SETTINGS_SVH

////////////////////////////////
// datapath sizing
////////////////////////////////

// width of one data word and of one instruction word
`define XLEN 32

// architectural registers, x0 included
`define REG_COUNT 32

// bits needed to index one register
`define REG_ADDR_W 5

`endif

//--- source/rv_isa_pkg.sv
`default_nettype none

package rv_isa_pkg;

`include "core_settings.svh"

    // one instruction word, same width as the datapath in RV32I
    typedef logic [`XLEN-1:0] inst_t;

    typedef logic [2:0] funct3_t;
    typedef logic [6:0] funct7_t;

    ////////////////////////////////
    // major opcodes
    ////////////////////////////////

    typedef enum logic [6:0] {
        OPC_OP     = 7'b0110011,
        OPC_OP_IMM = 7'b0010011,
        OPC_LUI    = 7'b0110111
    } opcode_e;

    ////////////////////////////////
    // minor opcodes
    ////////////////////////////////

    // shared by OP and OP-IMM
    localparam funct3_t F3_ADD_SUB = 3'b000;
    localparam funct3_t F3_SLL     = 3'b001;
    localparam funct3_t F3_SLT     = 3'b010;
    localparam funct3_t F3_SLTU    = 3'b011;
    localparam funct3_t F3_XOR     = 3'b100;
    localparam funct3_t F3_SRL_SRA = 3'b101;
    localparam funct3_t F3_OR      = 3'b110;
    localparam funct3_t F3_AND     = 3'b111;

    // funct7 values, alt selects SUB and SRA
    localparam funct7_t F7_BASE = 7'b0000000;
    localparam funct7_t F7_ALT  = 7'b0100000;

endpackage

`default_nettype wire

//--- source/core_pkg.sv
`default_nettype none

package core_pkg;

`include "core_settings.svh"

    typedef logic [`XLEN-1:0]       xword_t;
    typedef logic [`REG_ADDR_W-1:0] reg_idx_t;

    ////////////////////////////////
    // alu operations
    ////////////////////////////////

    // PASS_B forwards operand b untouched, used by LUI
    typedef enum logic [3:0] {
        ALU_ADD    = 4'd0,
        ALU_SUB    = 4'd1,
        ALU_SLL    = 4'd2,
        ALU_SLT    = 4'd3,
        ALU_SLTU   = 4'd4,
        ALU_XOR    = 4'd5,
        ALU_SRL    = 4'd6,
        ALU_SRA    = 4'd7,
        ALU_OR     = 4'd8,
        ALU_AND    = 4'd9,
        ALU_PASS_B = 4'd10
    } alu_op_e;

endpackage

`default_nettype wire

//--- source/decode_stage.sv
`timescale 1ns/1ps
`default_nettype none

module decode_stage
    import core_pkg::*;
    import rv_isa_pkg::*;
(
    input  logic     clk,
    input  logic     rst_i,
    input  logic     instr_valid_i,
    input  inst_t    instr_i,
    output reg_idx_t rs1_idx_o,
    output reg_idx_t rs2_idx_o,
    input  xword_t   rs1_val_i,
    input  xword_t   rs2_val_i,
    input  logic     fwd_we_i,
    input  reg_idx_t fwd_rd_i,
    input  xword_t   fwd_data_i,
    output logic     ex_valid_o,
    output alu_op_e  ex_op_o,
    output xword_t   ex_a_o,
    output xword_t   ex_b_o,
    output reg_idx_t ex_rd_o,
    output logic     ex_we_o,
    output logic     ex_illegal_o
);

    ////////////////////////////////
    // instruction fields
    ////////////////////////////////

    opcode_e  opcode;
    funct3_t  funct3;
    funct7_t  funct7;
    reg_idx_t rd;
    xword_t   imm_i;
    xword_t   imm_u;

    assign opcode    = opcode_e'(instr_i[6:0]);
    assign rd        = instr_i[11:7];
    assign funct3    = instr_i[14:12];
    assign rs1_idx_o = instr_i[19:15];
    assign rs2_idx_o = instr_i[24:20];
    assign funct7    = instr_i[31:25];

    // shift immediates sit in the low bits of imm_i
    assign imm_i = {{20{instr_i[31]}}, instr_i[31:20]};
    assign imm_u = {instr_i[31:12], 12'b0};

    ////////////////////////////////
    // alu op and legality
    ////////////////////////////////

    alu_op_e f3_op;
    alu_op_e dec_op;
    logic    dec_use_imm;
    logic    dec_illegal;
    xword_t  dec_imm;

    // funct3 gives the op for both register and immediate forms
    always_comb begin
        case (funct3)
            F3_SLL:     f3_op = ALU_SLL;
            F3_SLT:     f3_op = ALU_SLT;
            F3_SLTU:    f3_op = ALU_SLTU;
            F3_XOR:     f3_op = ALU_XOR;
            F3_SRL_SRA: f3_op = (funct7 == F7_ALT) ? ALU_SRA : ALU_SRL;
            F3_OR:      f3_op = ALU_OR;
            F3_AND:     f3_op = ALU_AND;
            default:    f3_op = ALU_ADD;
        endcase
    end

    always_comb begin
        dec_op      = ALU_ADD;
        dec_use_imm = 1'b0;
        dec_illegal = 1'b0;
        dec_imm     = imm_i;
        case (opcode)
            OPC_OP: begin
                if (funct3 == F3_ADD_SUB && funct7 == F7_ALT) begin
                    dec_op = ALU_SUB;
                end else begin
                    dec_op = f3_op;
                end
                // only SUB and SRA may use the alternate funct7
                dec_illegal = !(funct7 == F7_BASE ||
                                (funct7 == F7_ALT &&
                                 (funct3 == F3_ADD_SUB || funct3 == F3_SRL_SRA)));
            end
            OPC_OP_IMM: begin
                dec_op      = f3_op;
                dec_use_imm = 1'b1;
                // upper imm bits are funct7 for shifts only
                if (funct3 == F3_SLL) begin
                    dec_illegal = (funct7 != F7_BASE);
                end else if (funct3 == F3_SRL_SRA) begin
                    dec_illegal = (funct7 != F7_BASE) && (funct7 != F7_ALT);
                end
            end
            OPC_LUI: begin
                dec_op      = ALU_PASS_B;
                dec_use_imm = 1'b1;
                dec_imm     = imm_u;
            end
            default: begin
                dec_illegal = 1'b1;
            end
        endcase
    end

    ////////////////////////////////
    // operand forwarding
    ////////////////////////////////

    xword_t rs1_val;
    xword_t rs2_val;

    // fwd_we_i is never set for x0
    assign rs1_val = (fwd_we_i && fwd_rd_i == rs1_idx_o) ? fwd_data_i : rs1_val_i;
    assign rs2_val = (fwd_we_i && fwd_rd_i == rs2_idx_o) ? fwd_data_i : rs2_val_i;

    ////////////////////////////////
    // decode to execute register
    ////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst_i) begin
            ex_valid_o   <= 1'b0;
            ex_we_o      <= 1'b0;
            ex_illegal_o <= 1'b0;
        end else begin
            ex_valid_o   <= instr_valid_i;
            ex_we_o      <= instr_valid_i && !dec_illegal && (rd != '0);
            ex_illegal_o <= instr_valid_i && dec_illegal;
        end
    end

    always_ff @(posedge clk) begin
        ex_op_o <= dec_op;
        ex_a_o  <= rs1_val;
        ex_b_o  <= dec_use_imm ? dec_imm : rs2_val;
        ex_rd_o <= rd;
    end

    // an illegal instruction must never reach the register file
    assert property (@(posedge clk) disable iff (rst_i)
        !(ex_we_o && ex_illegal_o));

endmodule

`default_nettype wire

//--- source/execute_stage.sv
`timescale 1ns/1ps
`default_nettype none

`include "core_settings.svh"

module execute_stage
    import core_pkg::*;
(
    input  logic     ex_valid_i,
    input  alu_op_e  ex_op_i,
    input  xword_t   ex_a_i,
    input  xword_t   ex_b_i,
    input  reg_idx_t ex_rd_i,
    input  logic     ex_we_i,
    input  logic     ex_illegal_i,
    output logic     fwd_we_o,
    output reg_idx_t fwd_rd_o,
    output xword_t   fwd_data_o,
    output logic     res_valid_o,
    output logic     res_we_o,
    output reg_idx_t res_rd_o,
    output xword_t   res_data_o,
    output logic     res_illegal_o
);

    localparam int SHAMT_W = $clog2(`XLEN);

    logic [SHAMT_W-1:0] shamt;
    xword_t             alu_res;
    logic               write_en;

    assign shamt = ex_b_i[SHAMT_W-1:0];

    ////////////////////////////////
    // alu
    ////////////////////////////////

    always_comb begin
        case (ex_op_i)
            ALU_ADD:    alu_res = ex_a_i + ex_b_i;
            ALU_SUB:    alu_res = ex_a_i - ex_b_i;
            ALU_SLL:    alu_res = ex_a_i << shamt;
            ALU_SLT:    alu_res = {{(`XLEN-1){1'b0}}, $signed(ex_a_i) < $signed(ex_b_i)};
            ALU_SLTU:   alu_res = {{(`XLEN-1){1'b0}}, ex_a_i < ex_b_i};
            ALU_XOR:    alu_res = ex_a_i ^ ex_b_i;
            ALU_SRL:    alu_res = ex_a_i >> shamt;
            ALU_SRA:    alu_res = xword_t'($signed(ex_a_i) >>> shamt);
            ALU_OR:     alu_res = ex_a_i | ex_b_i;
            ALU_AND:    alu_res = ex_a_i & ex_b_i;
            ALU_PASS_B: alu_res = ex_b_i;
            default:    alu_res = '0;
        endcase
    end

    ////////////////////////////////
    // forwarding and result
    ////////////////////////////////

    // bubbles must not forward or write
    assign write_en = ex_valid_i && ex_we_i;

    assign fwd_we_o   = write_en;
    assign fwd_rd_o   = ex_rd_i;
    assign fwd_data_o = alu_res;

    assign res_valid_o   = ex_valid_i;
    assign res_we_o      = write_en;
    assign res_rd_o      = ex_rd_i;
    assign res_data_o    = alu_res;
    assign res_illegal_o = ex_valid_i && ex_illegal_i;

    // decode only ever hands over a known operation
    always_comb begin
        assert final (!ex_valid_i || ex_op_i inside {ALU_ADD, ALU_SUB, ALU_SLL, ALU_SLT,
            ALU_SLTU, ALU_XOR, ALU_SRL, ALU_SRA, ALU_OR, ALU_AND, ALU_PASS_B});
    end

endmodule

`default_nettype wire

//--- source/result_stage.sv
`timescale 1ns/1ps
`default_nettype none

`include "core_settings.svh"

module result_stage
    import core_pkg::*;
(
    input  logic     clk,
    input  logic     rst_i,
    input  reg_idx_t rs1_idx_i,
    input  reg_idx_t rs2_idx_i,
    output xword_t   rs1_val_o,
    output xword_t   rs2_val_o,
    input  logic     res_valid_i,
    input  logic     res_we_i,
    input  reg_idx_t res_rd_i,
    input  xword_t   res_data_i,
    input  logic     res_illegal_i,
    output logic     wb_valid_o,
    output reg_idx_t wb_rd_o,
    output xword_t   wb_data_o,
    output logic     illegal_o
);

    ////////////////////////////////
    // register file
    ////////////////////////////////

    // x0 has no storage
    xword_t regs [1:`REG_COUNT-1];
    logic   wr_en;

    assign wr_en = res_valid_i && res_we_i;

    always_ff @(posedge clk) begin
        if (rst_i) begin
            for (int i = 1; i < `REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en) begin
            regs[res_rd_i] <= res_data_i;
        end
    end

    assign rs1_val_o = (rs1_idx_i == '0) ? '0 : regs[rs1_idx_i];
    assign rs2_val_o = (rs2_idx_i == '0) ? '0 : regs[rs2_idx_i];

    ////////////////////////////////
    // write-back report
    ////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst_i) begin
            wb_valid_o <= 1'b0;
            illegal_o  <= 1'b0;
        end else begin
            wb_valid_o <= wr_en;
            illegal_o  <= res_valid_i && res_illegal_i;
        end
    end

    always_ff @(posedge clk) begin
        wb_rd_o   <= res_rd_i;
        wb_data_o <= res_data_i;
    end

    // decode drops the write enable for rd == x0
    assert property (@(posedge clk) disable iff (rst_i)
        wr_en |-> res_rd_i != '0);

endmodule

`default_nettype wire

//--- source/int_core_top.sv
`timescale 1ns/1ps
`default_nettype none

module int_core_top
    import core_pkg::*;
    import rv_isa_pkg::*;
(
    input  logic     clk,
    input  logic     rst_i,
    input  logic     instr_valid_i,
    input  inst_t    instr_i,
    output logic     wb_valid_o,
    output reg_idx_t wb_rd_o,
    output xword_t   wb_data_o,
    output logic     illegal_o
);

    // register file read ports
    reg_idx_t rs1_idx;
    reg_idx_t rs2_idx;
    xword_t   rs1_val;
    xword_t   rs2_val;

    // execute back to decode
    logic     fwd_we;
    reg_idx_t fwd_rd;
    xword_t   fwd_data;

    // decode to execute
    logic     ex_valid;
    alu_op_e  ex_op;
    xword_t   ex_a;
    xword_t   ex_b;
    reg_idx_t ex_rd;
    logic     ex_we;
    logic     ex_illegal;

    // execute to result
    logic     res_valid;
    logic     res_we;
    reg_idx_t res_rd;
    xword_t   res_data;
    logic     res_illegal;

    decode_stage decode0 (
        .clk           (clk),
        .rst_i         (rst_i),
        .instr_valid_i (instr_valid_i),
        .instr_i       (instr_i),
        .rs1_idx_o     (rs1_idx),
        .rs2_idx_o     (rs2_idx),
        .rs1_val_i     (rs1_val),
        .rs2_val_i     (rs2_val),
        .fwd_we_i      (fwd_we),
        .fwd_rd_i      (fwd_rd),
        .fwd_data_i    (fwd_data),
        .ex_valid_o    (ex_valid),
        .ex_op_o       (ex_op),
        .ex_a_o        (ex_a),
        .ex_b_o        (ex_b),
        .ex_rd_o       (ex_rd),
        .ex_we_o       (ex_we),
        .ex_illegal_o  (ex_illegal)
    );

    execute_stage execute0 (
        .ex_valid_i    (ex_valid),
        .ex_op_i       (ex_op),
        .ex_a_i        (ex_a),
        .ex_b_i        (ex_b),
        .ex_rd_i       (ex_rd),
        .ex_we_i       (ex_we),
        .ex_illegal_i  (ex_illegal),
        .fwd_we_o      (fwd_we),
        .fwd_rd_o      (fwd_rd),
        .fwd_data_o    (fwd_data),
        .res_valid_o   (res_valid),
        .res_we_o      (res_we),
        .res_rd_o      (res_rd),
        .res_data_o    (res_data),
        .res_illegal_o (res_illegal)
    );

    result_stage result0 (
        .clk           (clk),
        .rst_i         (rst_i),
        .rs1_idx_i     (rs1_idx),
        .rs2_idx_i     (rs2_idx),
        .rs1_val_o     (rs1_val),
        .rs2_val_o     (rs2_val),
        .res_valid_i   (res_valid),
        .res_we_i      (res_we),
        .res_rd_i      (res_rd),
        .res_data_i    (res_data),
        .res_illegal_i (res_illegal),
        .wb_valid_o    (wb_valid_o),
        .wb_rd_o       (wb_rd_o),
        .wb_data_o     (wb_data_o),
        .illegal_o     (illegal_o)
    );

endmodule

`default_nettype wire

//--- test/int_core_checker.sv
`timescale 1ns/1ps
`default_nettype none

module int_core_checker (
    input  logic        clk,
    input  logic        rst_i,
    input  logic        instr_valid_i,
    input  logic [31:0] instr_i,
    input  logic        wb_valid_i,
    input  logic [4:0]  wb_rd_i,
    input  logic [31:0] wb_data_i,
    input  logic        illegal_i,
    output int          err_count_o
);

    // x0 is never written, so it stays zero
    logic [31:0] model_regs [0:31];

    // expectation pipe, entry 1 is the older one
    logic        exp_wb      [0:1];
    logic        exp_illegal [0:1];
    logic [4:0]  exp_rd      [0:1];
    logic [31:0] exp_data    [0:1];

    ////////////////////////////////
    // reference model
    ////////////////////////////////

    function automatic void model_result(input logic [31:0] w, input logic [31:0] a,
                                         input logic [31:0] b_reg, output logic legal,
                                         output logic [31:0] res);
        logic [6:0]  opcode;
        logic [2:0]  f3;
        logic [6:0]  f7;
        logic [31:0] b;
        opcode = w[6:0];
        f3     = w[14:12];
        f7     = w[31:25];
        b      = b_reg;
        legal  = 1'b1;
        res    = 32'h0;
        if (opcode == 7'h37) begin
            res = {w[31:12], 12'h000};
        end else if (opcode == 7'h33 || opcode == 7'h13) begin
            if (opcode == 7'h33) begin
                legal = (f7 == 7'h00) || (f7 == 7'h20 && (f3 == 3'd0 || f3 == 3'd5));
            end else begin
                b = {{20{w[31]}}, w[31:20]};
                if (f3 == 3'd1) legal = (f7 == 7'h00);
                if (f3 == 3'd5) legal = (f7 == 7'h00) || (f7 == 7'h20);
            end
            case (f3)
                3'd0: res = (opcode == 7'h33 && f7 == 7'h20) ? a - b : a + b;
                3'd1: res = a << b[4:0];
                3'd2: res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                3'd3: res = (a < b) ? 32'd1 : 32'd0;
                3'd4: res = a ^ b;
                3'd5: begin
                    // arithmetic shift keeps the sign bit of a
                    if (f7 == 7'h20) begin
                        res = $signed(a) >>> b[4:0];
                    end else begin
                        res = a >> b[4:0];
                    end
                end
                3'd6: res = a | b;
                default: res = a & b;
            endcase
        end else begin
            legal = 1'b0;
        end
    endfunction

    ////////////////////////////////
    // output comparison
    ////////////////////////////////

    task automatic compare_outputs();
        if (exp_wb[1]) begin
            if (wb_valid_i !== 1'b1) begin
                $display("missing write-back pulse for x%0d at %0t", exp_rd[1], $time);
                err_count_o++;
            end else begin
                if (wb_rd_i !== exp_rd[1]) begin
                    $display("[FAIL] wb_rd: expected %0d, actual %0d", exp_rd[1], wb_rd_i);
                    err_count_o++;
                end
                if (wb_data_i !== exp_data[1]) begin
                    $display("[FAIL] wb_data x%0d: expected %h, actual %h",
                             exp_rd[1], exp_data[1], wb_data_i);
                    err_count_o++;
                end
            end
        end else if (wb_valid_i !== 1'b0) begin
            $display("unexpected write-back pulse for x%0d at %0t", wb_rd_i, $time);
            err_count_o++;
        end
        if (exp_illegal[1] && illegal_i !== 1'b1) begin
            $display("missing illegal pulse at %0t", $time);
            err_count_o++;
        end else if (!exp_illegal[1] && illegal_i !== 1'b0) begin
            $display("unexpected illegal pulse at %0t", $time);
            err_count_o++;
        end
    endtask

    // inputs and outputs are both settled at the falling edge
    always @(negedge clk) begin
        logic        legal;
        logic [31:0] res;
        logic [4:0]  rd;
        if (rst_i) begin
            err_count_o = 0;
            for (int i = 0; i < 32; i++) begin
                model_regs[i] = 32'h0;
            end
            for (int i = 0; i < 2; i++) begin
                exp_wb[i]      = 1'b0;
                exp_illegal[i] = 1'b0;
                exp_rd[i]      = 5'd0;
                exp_data[i]    = 32'h0;
            end
        end else begin
            compare_outputs();
            exp_wb[1]      = exp_wb[0];
            exp_illegal[1] = exp_illegal[0];
            exp_rd[1]      = exp_rd[0];
            exp_data[1]    = exp_data[0];
            rd = instr_i[11:7];
            model_result(instr_i, model_regs[instr_i[19:15]], model_regs[instr_i[24:20]],
                         legal, res);
            exp_wb[0]      = instr_valid_i && legal && rd != 5'd0;
            exp_illegal[0] = instr_valid_i && !legal;
            exp_rd[0]      = rd;
            exp_data[0]    = res;
            // writes land in program order
            if (exp_wb[0]) begin
                model_regs[rd] = res;
            end
        end
    end

endmodule

`default_nettype wire

//--- test/int_core_tb.sv
`timescale 1ns/1ps
`default_nettype none

module int_core_tb;

    localparam int RANDOM_CYCLES = 400;
    localparam int CYCLE_LIMIT   = 600;

    logic        clk;
    logic        rst_i;
    logic        instr_valid_i;
    logic [31:0] instr_i;
    logic        wb_valid_o;
    logic [4:0]  wb_rd_o;
    logic [31:0] wb_data_o;
    logic        illegal_o;
    int          err_count;
    int          cycle_count;

    int_core_top dut0 (
        .clk           (clk),
        .rst_i         (rst_i),
        .instr_valid_i (instr_valid_i),
        .instr_i       (instr_i),
        .wb_valid_o    (wb_valid_o),
        .wb_rd_o       (wb_rd_o),
        .wb_data_o     (wb_data_o),
        .illegal_o     (illegal_o)
    );

    int_core_checker checker0 (
        .clk           (clk),
        .rst_i         (rst_i),
        .instr_valid_i (instr_valid_i),
        .instr_i       (instr_i),
        .wb_valid_i    (wb_valid_o),
        .wb_rd_i       (wb_rd_o),
        .wb_data_i     (wb_data_o),
        .illegal_i     (illegal_o),
        .err_count_o   (err_count)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    ////////////////////////////////
    // instruction encoders
    ////////////////////////////////

    function automatic logic [31:0] r_type(input logic [6:0] f7, input logic [4:0] rs2,
                                           input logic [4:0] rs1, input logic [2:0] f3,
                                           input logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, 7'h33};
    endfunction

    function automatic logic [31:0] i_type(input logic [11:0] imm, input logic [4:0] rs1,
                                           input logic [2:0] f3, input logic [4:0] rd);
        return {imm, rs1, f3, rd, 7'h13};
    endfunction

    function automatic logic [31:0] lui(input logic [19:0] imm, input logic [4:0] rd);
        return {imm, rd, 7'h37};
    endfunction

    task automatic issue(input logic [31:0] w);
        @(posedge clk);
        #1;
        instr_valid_i = 1'b1;
        instr_i       = w;
    endtask

    // the word is junk and must be ignored
    task automatic bubble();
        @(posedge clk);
        #1;
        instr_valid_i = 1'b0;
        instr_i       = $urandom;
    endtask

    task automatic random_cycle();
        int          pick;
        logic [4:0]  rd;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [2:0]  f3;
        logic [6:0]  f7;
        logic [11:0] imm;
        logic [31:0] w;
        pick = int'($urandom % 100);
        rd   = 5'($urandom % 8);
        rs1  = 5'($urandom % 8);
        rs2  = 5'($urandom % 8);
        f3   = 3'($urandom);
        f7   = 7'h00;
        imm  = 12'($urandom);
        w    = 32'h0;
        if (pick < 20) begin
            bubble();
        end else if (pick < 30) begin
            case ($urandom % 3)
                0: begin
                    w = $urandom;
                    if (w[6:0] inside {7'h33, 7'h13, 7'h37}) w[6:0] = 7'h7f;
                end
                1: w = r_type(7'h01 | 7'($urandom), rs2, rs1, f3, rd);
                default: w = i_type({7'h01 | 7'($urandom), 5'($urandom)}, rs1, 3'd1, rd);
            endcase
            issue(w);
        end else begin
            case ($urandom % 4)
                0, 1: begin
                    if ((f3 == 3'd0 || f3 == 3'd5) && $urandom % 2 == 1) f7 = 7'h20;
                    w = r_type(f7, rs2, rs1, f3, rd);
                end
                2: begin
                    if (f3 == 3'd1) imm[11:5] = 7'h00;
                    if (f3 == 3'd5) imm[11:5] = ($urandom % 2 == 1) ? 7'h20 : 7'h00;
                    w = i_type(imm, rs1, f3, rd);
                end
                default: w = lui(20'($urandom), rd);
            endcase
            issue(w);
        end
    endtask

    ////////////////////////////////
    // main sequence
    ////////////////////////////////

    initial begin
        void'($urandom(32'h3d5a));
        rst_i         = 1'b1;
        instr_valid_i = 1'b0;
        instr_i       = 32'h0;
        repeat (4) @(posedge clk);
        #1;
        rst_i = 1'b0;

        // operands straight after reset read zero
        issue(r_type(7'h00, 5'd6, 5'd5, 3'd0, 5'd3));
        issue(i_type(12'h123, 5'd0, 3'd0, 5'd1));
        issue(i_type(12'hffb, 5'd0, 3'd0, 5'd2));
        // x2 forwarded, x1 from the register file
        issue(r_type(7'h00, 5'd2, 5'd1, 3'd0, 5'd3));
        issue(r_type(7'h20, 5'd1, 5'd3, 3'd0, 5'd4));
        for (int f = 1; f < 8; f++) begin
            issue(r_type(7'h00, 5'd1, 5'd2, 3'(f), 5'(8 + f)));
        end
        issue(r_type(7'h20, 5'd1, 5'd2, 3'd5, 5'd16));
        issue(lui(20'hdead5, 5'd5));
        for (int f = 0; f < 8; f++) begin
            issue(i_type((f == 1 || f == 5) ? 12'h004 : 12'h8a5, 5'd5, 3'(f), 5'(17 + f)));
        end
        issue(i_type(12'h404, 5'd5, 3'd5, 5'd25));
        bubble();
        // write to x0, then read it back
        issue(i_type(12'h005, 5'd1, 3'd0, 5'd0));
        issue(r_type(7'h00, 5'd0, 5'd1, 3'd0, 5'd7));
        // unsupported encodings aimed at x1 and x2
        issue(32'hffff_ffff);
        issue(r_type(7'h01, 5'd2, 5'd1, 3'd0, 5'd1));
        issue(i_type(12'h404, 5'd1, 3'd1, 5'd2));
        issue(r_type(7'h00, 5'd2, 5'd1, 3'd6, 5'd8));

        for (int i = 0; i < RANDOM_CYCLES; i++) begin
            random_cycle();
        end
        // let the last results drain
        repeat (4) bubble();

        $display("errors: %0d after %0d cycles", err_count, cycle_count);
        if (err_count == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

    // guards against a run that never ends
    initial begin
        cycle_count = 0;
        while (cycle_count < CYCLE_LIMIT) begin
            @(posedge clk);
            cycle_count++;
        end
        $display("timeout: run still going after %0d cycles", CYCLE_LIMIT);
        $display("STATUS: FAIL");
        $finish;
    end

endmodule

`default_nettype wire

//--- sources.f
+incdir+include
source/rv_isa_pkg.sv
source/core_pkg.sv
source/decode_stage.sv
source/execute_stage.sv
source/result_stage.sv
source/int_core_top.sv
test/int_core_checker.sv
test/int_core_tb.sv

//--- Makefile
TOP := int_core_tb

all: run

obj_dir/V$(TOP): sources.f $(wildcard source/*.sv include/*.svh test/*.sv)
	verilator --binary --timing --assert -f sources.f --top-module $(TOP) -o V$(TOP)

run: obj_dir/V$(TOP)
	./obj_dir/V$(TOP) | tee sim.log
	grep -q "STATUS: PASS" sim.log

lint:
	verilator --lint-only --timing --assert -f sources.f --top-module $(TOP)

clean:
	rm -rf obj_dir sim.log

.PHONY: all run lint clean
